//--- sources.f
io_pkg.sv
byte_collector.sv
transfer_sequencer.sv
byte_serializer.sv
io_bridge.sv
tb_clock.sv
io_bridge_tb.sv

//--- io_bridge_tb.sv
module io_bridge_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int block_bytes  = 16;
  localparam int block_w      = block_bytes * io_pkg::byte_w;
  localparam int flag_timeout = 200;  // Cycles allowed per wait

  logic               clk;
  logic               reset_n;
  io_pkg::flag_t      to_hw_sig;
  io_pkg::byte_t      to_hw_port;
  io_pkg::flag_t      to_sw_sig;
  io_pkg::byte_t      to_sw_port;
  logic [block_w-1:0] msg_en;
  logic [block_w-1:0] key;
  logic               io_ready;
  logic [block_w-1:0] msg_de;
  logic               aes_ready;

  int            errors;
  int            timeouts;
  logic          aborted;
  logic          in_readback;
  logic [31:0]   rng_state;
  io_pkg::byte_t msg_bytes [block_bytes];
  io_pkg::byte_t key_bytes [block_bytes];

  tb_clock clock_i (
    .clk     (clk),
    .reset_n (reset_n)
  );

  io_bridge #(
    .block_bytes (block_bytes)
  ) dut_i (
    .clk        (clk),
    .reset_n    (reset_n),
    .to_hw_sig  (to_hw_sig),
    .to_hw_port (to_hw_port),
    .to_sw_sig  (to_sw_sig),
    .to_sw_port (to_sw_port),
    .msg_en     (msg_en),
    .key        (key),
    .io_ready   (io_ready),
    .msg_de     (msg_de),
    .aes_ready  (aes_ready)
  );

  // Engine model XORs both blocks
  always @(posedge clk) msg_de <= msg_en ^ key;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic io_pkg::byte_t next_byte();
    rng_state = xorshift32(rng_state);
    return rng_state[15:8];
  endfunction

  // Byte 0 ends up in the top lane after all shifts
  function automatic logic [block_w-1:0] pack_block(input io_pkg::byte_t bytes [block_bytes]);
    logic [block_w-1:0] word;
    word = '0;
    for (int i = 0; i < block_bytes; i++) begin
      word = {word[block_w-io_pkg::byte_w-1:0], bytes[i]};
    end
    return word;
  endfunction

  function automatic void report_mismatch(input string name, input logic [block_w-1:0] expected,
                                          input logic [block_w-1:0] actual);
    errors++;
    $display("FAIL at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
  endfunction

  assert property (@(posedge clk) disable iff (!reset_n) io_ready && !aes_ready |=> io_ready)
    else report_mismatch("io_ready", 1, $sampled(io_ready));
  assert property (@(posedge clk) disable iff (!reset_n)
                   io_ready |-> to_sw_sig == io_pkg::strobe_idle)
    else report_mismatch("to_sw_sig", io_pkg::strobe_idle, $sampled(to_sw_sig));
  assert property (@(posedge clk) disable iff (!reset_n)
                   io_ready && aes_ready |=> to_sw_sig == io_pkg::strobe_two)
    else report_mismatch("to_sw_sig", io_pkg::strobe_two, $sampled(to_sw_sig));
  // Port stays quiet outside read-back bytes
  assert property (@(posedge clk) disable iff (!reset_n)
                   !(in_readback && to_sw_sig == io_pkg::strobe_one) |-> to_sw_port == '0)
    else report_mismatch("to_sw_port", 0, $sampled(to_sw_port));

  task automatic wait_for_flag(input io_pkg::flag_t want, input string what);
    int waited;
    waited = 0;
    if (!aborted) begin
      @(negedge clk);
      while (to_sw_sig !== want && waited < flag_timeout) begin
        @(negedge clk);
        waited++;
      end
      if (to_sw_sig !== want) begin
        timeouts++;
        aborted = 1'b1;
        $display("Timeout at %0d ns: the bridge never showed %s", $time, what);
      end
    end
  endtask

  task automatic wait_for_io_ready();
    int waited;
    waited = 0;
    if (!aborted) begin
      @(negedge clk);
      while (io_ready !== 1'b1 && waited < flag_timeout) begin
        @(negedge clk);
        waited++;
      end
      if (io_ready !== 1'b1) begin
        timeouts++;
        aborted = 1'b1;
        $display("Timeout at %0d ns: io_ready never rose after the run command", $time);
      end
    end
  endtask

  // Message uses offer one / answer two, key the other way round
  task automatic load_block(input io_pkg::flag_t cmd, input io_pkg::flag_t offer,
                            input io_pkg::flag_t answer, input io_pkg::byte_t bytes [block_bytes]);
    for (int i = 0; i < block_bytes; i++) begin
      @(posedge clk);
      to_hw_port <= bytes[i];
      to_hw_sig  <= (i == 0) ? cmd : offer;
      wait_for_flag(io_pkg::strobe_one, "strobe_one for a load byte");
      @(posedge clk);
      to_hw_sig <= answer;
      wait_for_flag(io_pkg::strobe_idle, "strobe_idle after a load byte");
    end
    @(posedge clk);
    to_hw_sig <= io_pkg::strobe_idle;
    @(negedge clk);
  endtask

  task automatic compare_blocks();
    assert (msg_en == pack_block(msg_bytes))
      else report_mismatch("msg_en", pack_block(msg_bytes), msg_en);
    assert (key == pack_block(key_bytes))
      else report_mismatch("key", pack_block(key_bytes), key);
  endtask

  task automatic run_and_read();
    int delay;
    @(posedge clk);
    to_hw_sig <= io_pkg::cmd_run;
    wait_for_io_ready();
    if (!aborted) begin
      rng_state = xorshift32(rng_state);
      delay = 1 + int'(rng_state % 20);
      repeat (delay - 1) begin
        @(negedge clk);
        assert (io_ready) else report_mismatch("io_ready", 1, io_ready);
        assert (to_sw_sig == io_pkg::strobe_idle)
          else report_mismatch("to_sw_sig", io_pkg::strobe_idle, to_sw_sig);
      end
      @(posedge clk);
      aes_ready <= 1'b1;
      @(posedge clk);
      aes_ready <= 1'b0;
      @(negedge clk);
      assert (to_sw_sig == io_pkg::strobe_two)
        else report_mismatch("to_sw_sig", io_pkg::strobe_two, to_sw_sig);
    end
    for (int i = 0; i < block_bytes; i++) begin
      @(posedge clk);
      to_hw_sig   <= io_pkg::strobe_one;
      in_readback <= 1'b1;
      wait_for_flag(io_pkg::strobe_one, "strobe_one for a result byte");
      if (!aborted) begin
        assert (to_sw_port == (msg_bytes[i] ^ key_bytes[i]))
          else report_mismatch("to_sw_port", msg_bytes[i] ^ key_bytes[i], to_sw_port);
      end
      @(posedge clk);
      to_hw_sig <= io_pkg::strobe_two;
      wait_for_flag(io_pkg::strobe_idle, "strobe_idle after a result byte");
    end
    @(posedge clk);
    to_hw_sig   <= io_pkg::strobe_idle;
    in_readback <= 1'b0;
    @(negedge clk);
  endtask

  initial begin
    int waited;
    errors      = 0;
    timeouts    = 0;
    aborted     = 1'b0;
    in_readback = 1'b0;
    rng_state   = 32'd84361;
    to_hw_sig   = io_pkg::cmd_none;
    to_hw_port  = '0;
    aes_ready   = 1'b0;
    msg_de      = '0;
    for (int i = 0; i < block_bytes; i++) begin
      msg_bytes[i] = '0;
      key_bytes[i] = '0;
    end

    waited = 0;
    while (reset_n !== 1'b1 && waited < 100) begin
      @(negedge clk);
      waited++;
    end
    if (reset_n !== 1'b1) begin
      timeouts++;
      aborted = 1'b1;
      $display("Timeout at %0d ns: reset was never released", $time);
    end

    // First cycle out of reset still shows the reset phase
    assert (to_sw_sig == io_pkg::strobe_reset)
      else report_mismatch("to_sw_sig", io_pkg::strobe_reset, to_sw_sig);
    assert (io_ready == 1'b0) else report_mismatch("io_ready", 0, io_ready);
    assert (msg_en == '0) else report_mismatch("msg_en", 0, msg_en);
    assert (key == '0) else report_mismatch("key", 0, key);
    assert (to_sw_port == '0) else report_mismatch("to_sw_port", 0, to_sw_port);
    @(negedge clk);
    assert (to_sw_sig == io_pkg::strobe_idle)
      else report_mismatch("to_sw_sig", io_pkg::strobe_idle, to_sw_sig);

    for (int i = 0; i < block_bytes; i++) msg_bytes[i] = next_byte();
    load_block(io_pkg::cmd_msg, io_pkg::strobe_one, io_pkg::strobe_two, msg_bytes);
    compare_blocks();

    for (int i = 0; i < block_bytes; i++) key_bytes[i] = next_byte();
    load_block(io_pkg::cmd_key, io_pkg::strobe_two, io_pkg::strobe_one, key_bytes);
    compare_blocks();
    run_and_read();

    // New message, old key kept
    for (int i = 0; i < block_bytes; i++) msg_bytes[i] = next_byte();
    load_block(io_pkg::cmd_msg, io_pkg::strobe_one, io_pkg::strobe_two, msg_bytes);
    compare_blocks();
    run_and_read();

    repeat (2) @(negedge clk);
    $display("Run complete: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- tb_clock.sv
module tb_clock (
  output logic clk,
  output logic reset_n
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int half_period  = 50;
  localparam int reset_cycles = 16;

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // Released on a rising edge, the DUT sees it one edge later
  initial begin
    reset_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    reset_n <= 1'b1;
  end

endmodule

//--- io_bridge.sv
module io_bridge #(
  parameter int block_bytes = 16
) (
  input  logic                                  clk,
  input  logic                                  reset_n,
  input  io_pkg::flag_t                         to_hw_sig,
  input  io_pkg::byte_t                         to_hw_port,
  output io_pkg::flag_t                         to_sw_sig,
  output io_pkg::byte_t                         to_sw_port,
  output logic [block_bytes*io_pkg::byte_w-1:0] msg_en,
  output logic [block_bytes*io_pkg::byte_w-1:0] key,
  output logic                                  io_ready,
  input  logic [block_bytes*io_pkg::byte_w-1:0] msg_de,
  input  logic                                  aes_ready
);

  logic                           capture_msg;
  logic                           capture_key;
  logic                           send;
  logic                           load_result;
  logic [$clog2(block_bytes)-1:0] byte_index;  // Shared by both data paths

  transfer_sequencer #(
    .block_bytes (block_bytes)
  ) sequencer_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .to_hw_sig   (to_hw_sig),
    .aes_ready   (aes_ready),
    .to_sw_sig   (to_sw_sig),
    .capture_msg (capture_msg),
    .capture_key (capture_key),
    .send        (send),
    .load_result (load_result),
    .io_ready    (io_ready),
    .byte_index  (byte_index)
  );

  // Input side
  byte_collector #(
    .block_bytes (block_bytes)
  ) collector_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .to_hw_port  (to_hw_port),
    .capture_msg (capture_msg),
    .capture_key (capture_key),
    .byte_index  (byte_index),
    .msg_en      (msg_en),
    .key         (key)
  );

  // Output side
  byte_serializer #(
    .block_bytes (block_bytes)
  ) serializer_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .msg_de      (msg_de),
    .load_result (load_result),
    .send        (send),
    .byte_index  (byte_index),
    .to_sw_port  (to_sw_port)
  );

endmodule

//--- byte_serializer.sv
module byte_serializer #(
  parameter int block_bytes = 16
) (
  input  logic                                  clk,
  input  logic                                  reset_n,
  input  logic [block_bytes*io_pkg::byte_w-1:0] msg_de,
  input  logic                                  load_result,
  input  logic                                  send,
  input  logic [$clog2(block_bytes)-1:0]        byte_index,
  output io_pkg::byte_t                         to_sw_port
);

  localparam int idx_w = $clog2(block_bytes);

  logic [block_bytes*io_pkg::byte_w-1:0] result;
  logic [idx_w-1:0]                      lane;

  // Engine output is held here so it need not stay stable afterwards
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      result <= '0;
    end else if (load_result) begin
      result <= msg_de;
    end
  end

  assign lane = idx_w'(block_bytes - 1) - byte_index;  // Top byte goes first

  assign to_sw_port = send ? result[lane*io_pkg::byte_w +: io_pkg::byte_w] : '0;

endmodule

//--- transfer_sequencer.sv
module transfer_sequencer #(
  parameter int block_bytes = 16
) (
  input  logic                           clk,
  input  logic                           reset_n,
  input  io_pkg::flag_t                  to_hw_sig,
  input  logic                           aes_ready,
  output io_pkg::flag_t                  to_sw_sig,
  output logic                           capture_msg,
  output logic                           capture_key,
  output logic                           send,
  output logic                           load_result,
  output logic                           io_ready,
  output logic [$clog2(block_bytes)-1:0] byte_index
);

  localparam int idx_w = $clog2(block_bytes);

  typedef enum logic [3:0] {
    st_reset,
    st_idle,
    st_read_msg,
    st_ack_msg,
    st_read_key,
    st_ack_key,
    st_run,
    st_result,
    st_send,
    st_got_ack
  } state_e;

  state_e             state;
  state_e             next_state;
  logic [idx_w-1:0]   count;
  logic [idx_w-1:0]   next_count;
  logic               last_byte;
  io_pkg::flag_word_u flag_word;

  assign flag_word  = to_hw_sig;
  assign last_byte  = count == idx_w'(block_bytes - 1);
  assign byte_index = count;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state <= st_reset;
      count <= '0;
    end else begin
      state <= next_state;
      count <= next_count;
    end
  end

  always_comb begin
    next_state = state;
    next_count = count;
    case (state)
      st_reset: next_state = st_idle;

      st_idle: begin
        next_count = '0;
        case (flag_word.cmd)
          io_pkg::cmd_msg: next_state = st_read_msg;
          io_pkg::cmd_key: next_state = st_read_key;
          io_pkg::cmd_run: next_state = st_run;
          default:         next_state = st_idle;
        endcase
      end

      // Message rounds: software goes two then one
      st_read_msg: begin
        if (flag_word.strobe == io_pkg::strobe_two) next_state = st_ack_msg;
      end
      st_ack_msg: begin
        if (last_byte) begin
          if (flag_word.strobe == io_pkg::strobe_idle) next_state = st_idle;
        end else if (flag_word.strobe == io_pkg::strobe_one) begin
          next_state = st_read_msg;
          next_count = count + 1'b1;
        end
      end

      // Key rounds use the opposite strobe order
      st_read_key: begin
        if (flag_word.strobe == io_pkg::strobe_one) next_state = st_ack_key;
      end
      st_ack_key: begin
        if (last_byte) begin
          if (flag_word.strobe == io_pkg::strobe_idle) next_state = st_idle;
        end else if (flag_word.strobe == io_pkg::strobe_two) begin
          next_state = st_read_key;
          next_count = count + 1'b1;
        end
      end

      st_run: begin
        if (aes_ready) next_state = st_result;  // Engine latency is open-ended
      end
      st_result: begin
        if (flag_word.strobe == io_pkg::strobe_one) next_state = st_send;
      end

      st_send: begin
        if (flag_word.strobe == io_pkg::strobe_two) next_state = st_got_ack;
      end
      st_got_ack: begin
        if (last_byte) begin
          if (flag_word.strobe == io_pkg::strobe_idle) next_state = st_idle;
        end else if (flag_word.strobe == io_pkg::strobe_one) begin
          next_state = st_send;
          next_count = count + 1'b1;
        end
      end

      default: next_state = st_reset;
    endcase
  end

  // Flag out is a pure decode of the state register
  always_comb begin
    case (state)
      st_reset:    to_sw_sig = io_pkg::strobe_reset;
      st_read_msg: to_sw_sig = io_pkg::strobe_one;
      st_read_key: to_sw_sig = io_pkg::strobe_one;
      st_send:     to_sw_sig = io_pkg::strobe_one;
      st_result:   to_sw_sig = io_pkg::strobe_two;
      default:     to_sw_sig = io_pkg::strobe_idle;
    endcase
  end

  assign capture_msg = state == st_read_msg;
  assign capture_key = state == st_read_key;
  assign send        = state == st_send;
  assign io_ready    = state == st_run;
  assign load_result = io_ready && aes_ready;  // One pulse, state leaves run next edge

endmodule

//--- byte_collector.sv
module byte_collector #(
  parameter int block_bytes = 16
) (
  input  logic                                  clk,
  input  logic                                  reset_n,
  input  io_pkg::byte_t                         to_hw_port,
  input  logic                                  capture_msg,
  input  logic                                  capture_key,
  input  logic [$clog2(block_bytes)-1:0]        byte_index,
  output logic [block_bytes*io_pkg::byte_w-1:0] msg_en,
  output logic [block_bytes*io_pkg::byte_w-1:0] key
);

  localparam int idx_w = $clog2(block_bytes);

  logic [idx_w-1:0] lane;

  // Index 0 lands in the top byte lane
  assign lane = idx_w'(block_bytes - 1) - byte_index;

  // Capture repeats every cycle of the read phase, last sample wins
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      msg_en <= '0;
      key    <= '0;
    end else begin
      if (capture_msg) begin
        msg_en[lane*io_pkg::byte_w +: io_pkg::byte_w] <= to_hw_port;
      end
      if (capture_key) begin
        key[lane*io_pkg::byte_w +: io_pkg::byte_w] <= to_hw_port;
      end
    end
  end

endmodule

//--- io_pkg.sv
package io_pkg;

  // Width of the byte data ports
  parameter int byte_w = 8;

  typedef logic [byte_w-1:0] byte_t;

  // Two-bit flag word, same width both ways
  typedef logic [1:0] flag_t;

  // Commands accepted while idle
  typedef enum logic [1:0] {
    cmd_none = 2'd0,
    cmd_msg  = 2'd1,
    cmd_key  = 2'd2,
    cmd_run  = 2'd3
  } cmd_e;

  // Handshake phases during a transfer
  typedef enum logic [1:0] {
    strobe_idle  = 2'd0,
    strobe_one   = 2'd1,
    strobe_two   = 2'd2,
    strobe_reset = 2'd3
  } strobe_e;

  // Incoming flags mean a command in idle and a strobe everywhere else
  typedef union packed {
    cmd_e    cmd;
    strobe_e strobe;
  } flag_word_u;

endpackage
